// ==== run.sh ====
#!/bin/sh
# Build and run the sh_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_sh_core -o tb_sh_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sh_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1

// ==== tb.f ====
verilog/sh_pkg.sv
verilog/fwd_if.sv
verilog/sh_regfile.sv
verilog/sh_bypass.sv
verilog/sh_alu.sv
verilog/sh_stages.sv
verilog/sh_core.sv
tb/tb_sh_core.sv

// ==== tb/tb_sh_core.sv ====
`timescale 1ns/100ps

module tb_sh_core;

	import sh_pkg::*;

	logic     CLK;
	logic     RST_N;
	logic     CE;
	logic     op_valid;
	alu_op_t  op_code;
	reg_num_t op_rn;
	reg_num_t op_rm;
	imm8_t    op_imm;
	logic     wb_valid;
	reg_num_t wb_rn;
	word_t    wb_data;
	logic     t_flag;

	// In-order reference model
	word_t    model_regs [REG_COUNT];
	logic     model_t;
	reg_num_t exp_rn_q [$];
	word_t    exp_data_q [$];
	reg_num_t exp_rn;
	word_t    exp_data;

	logic     ce_at_edge;
	logic     t_stage1;
	logic     t_delayed;
	logic     checks_on;
	logic     prev_valid;
	reg_num_t prev_rn;
	word_t    prev_data;
	logic     prev_t;
	int       issued;
	int       pulses;
	int       data_errs;
	int       t_errs;
	int       hold_errs;
	int       other_errs;
	integer   seed;
	string    test_name;

	sh_core i_sh_core (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.CE       (CE),
		.op_valid (op_valid),
		.op_code  (op_code),
		.op_rn    (op_rn),
		.op_rm    (op_rm),
		.op_imm   (op_imm),
		.wb_valid (wb_valid),
		.wb_rn    (wb_rn),
		.wb_data  (wb_data),
		.t_flag   (t_flag)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// Model T as seen one CE edge later
	always @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ce_at_edge <= 1'b0;
			t_stage1   <= 1'b0;
			t_delayed  <= 1'b0;
		end
		else begin
			ce_at_edge <= CE;
			if (CE) begin
				t_stage1  <= model_t;
				t_delayed <= t_stage1;
			end
		end
	end

	//******************************
	// Output checks at mid-cycle
	//******************************
	always @(negedge CLK) begin
		if (checks_on && ce_at_edge) begin
			assert (t_flag == t_delayed) else begin
				t_errs++;
				$display("[ERROR] %s: t_flag expected %b actual %b",
					test_name, t_delayed, t_flag);
			end
			if (wb_valid) begin
				pulses++;
				if (exp_rn_q.size() == 0) begin
					other_errs++;
					$display("Write-back seen with no operation outstanding");
				end
				else begin
					exp_rn   = exp_rn_q.pop_front();
					exp_data = exp_data_q.pop_front();
					assert (wb_rn == exp_rn) else begin
						data_errs++;
						$display("[ERROR] %s: wb_rn expected %0d actual %0d",
							test_name, exp_rn, wb_rn);
					end
					assert (wb_data == exp_data) else begin
						data_errs++;
						$display("[ERROR] %s: wb_data expected %h actual %h",
							test_name, exp_data, wb_data);
					end
				end
			end
		end
		else if (checks_on) begin
			assert (wb_valid == prev_valid && wb_rn == prev_rn && wb_data == prev_data
				&& t_flag == prev_t) else begin
				hold_errs++;
				$display("[ERROR] %s: held outputs expected %b/%0d/%h/%b actual %b/%0d/%h/%b",
					test_name, prev_valid, prev_rn, prev_data, prev_t,
					wb_valid, wb_rn, wb_data, t_flag);
			end
		end
		prev_valid = wb_valid;
		prev_rn    = wb_rn;
		prev_data  = wb_data;
		prev_t     = t_flag;
	end

	task automatic model_exec(input alu_op_t op, input reg_num_t rn, input reg_num_t rm,
		input imm8_t imm);
		word_t       a;
		word_t       b;
		word_t       r;
		word_t       imm_ext;
		logic [32:0] sum;
		logic        wr;
		a       = model_regs[rn];
		b       = model_regs[rm];
		imm_ext = {{24{imm[7]}}, imm};
		wr      = 1'b1;
		case (op)
			ADD:  r = a + b;
			ADDC: begin
				sum     = {1'b0, a} + {1'b0, b} + {32'b0, model_t};
				r       = sum[31:0];
				model_t = sum[32];
			end
			SUB:  r = a - b;
			AND_: r = a & b;
			OR_:  r = a | b;
			XOR_: r = a ^ b;
			MOV:  r = b;
			MOVI: r = imm_ext;
			ADDI: r = a + imm_ext;
			CMP_EQ: begin
				r       = a - b;
				model_t = (a == b);
				wr      = 1'b0;
			end
			CMP_HS: begin
				r       = a - b;
				model_t = (a >= b);
				wr      = 1'b0;
			end
			CMP_GT: begin
				r       = a - b;
				model_t = ($signed(a) > $signed(b));
				wr      = 1'b0;
			end
			SHLL: begin
				r       = {a[30:0], 1'b0};
				model_t = a[31];
			end
			SHLR: begin
				r       = {1'b0, a[31:1]};
				model_t = a[0];
			end
			default: r = '0;
		endcase
		if (wr) begin
			model_regs[rn] = r;
		end
		exp_rn_q.push_back(rn);
		exp_data_q.push_back(r);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge CLK);
			#1;
		end
	endtask

	// Called 1 ns after an edge with CE high
	task automatic issue_op(input alu_op_t op, input reg_num_t rn, input reg_num_t rm,
		input imm8_t imm);
		op_valid = 1'b1;
		op_code  = op;
		op_rn    = rn;
		op_rm    = rm;
		op_imm   = imm;
		model_exec(op, rn, rm, imm);
		issued++;
		idle(1);
		op_valid = 1'b0;
	endtask

	task automatic ce_pause(input int n);
		CE = 1'b0;
		idle(n);
		CE = 1'b1;
	endtask

	task automatic dependent_chain(input int gap);
		issue_op(MOVI, 4'd1, 4'd0, 8'h05);
		idle(gap);
		issue_op(ADD, 4'd1, 4'd1, 8'h00);
		idle(gap);
		issue_op(ADDI, 4'd1, 4'd0, 8'hfd);
		idle(gap);
		issue_op(MOV, 4'd2, 4'd1, 8'h00);
		idle(gap);
		issue_op(SHLL, 4'd1, 4'd0, 8'h00);
		idle(gap);
		issue_op(XOR_, 4'd2, 4'd1, 8'h00);
		idle(gap);
		issue_op(SUB, 4'd1, 4'd2, 8'h00);
		idle(gap);
		issue_op(OR_, 4'd2, 4'd1, 8'h00);
	endtask

	// Compares and shifts feeding ADDC directly
	task automatic t_into_addc(input int count);
		int unsigned r;
		alu_op_t     cmp;
		for (int i = 0; i < count; i++) begin
			r   = $random(seed);
			cmp = (i % 3 == 0) ? CMP_EQ : ((i % 3 == 1) ? CMP_HS : CMP_GT);
			issue_op(MOVI, 4'd3, 4'd0, r[7:0]);
			issue_op(MOVI, 4'd4, 4'd0, r[0] ? r[7:0] : r[15:8]);
			issue_op(cmp, 4'd3, 4'd4, 8'h00);
			issue_op(ADDC, 4'd5, 4'd3, 8'h00);
			issue_op(r[1] ? SHLL : SHLR, 4'd3, 4'd0, 8'h00);
			issue_op(ADDC, 4'd5, 4'd4, 8'h00);
		end
	endtask

	task automatic random_ops(input int count, input logic with_stalls);
		int unsigned r;
		logic [3:0]  op_sel;
		for (int i = 0; i < count; i++) begin
			r      = $random(seed);
			op_sel = 4'(r % 14);
			issue_op(alu_op_t'(op_sel), r[7:4], r[11:8], r[19:12]);
			r = $random(seed);
			idle(r % 4);
			if (with_stalls && r[8:6] == 3'd0) begin
				ce_pause(1 + int'(r[13:11]));
			end
		end
	endtask

	task automatic finish_run(input logic timed_out);
		$display("Errors: data %0d, t_flag %0d, hold %0d, other %0d (ops %0d, write-backs %0d)",
			data_errs, t_errs, hold_errs, other_errs, issued, pulses);
		if (!timed_out && data_errs + t_errs + hold_errs + other_errs == 0) begin
			$display("=== PASS ===");
		end
		else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	//******************************
	// Main sequence
	//******************************
	initial begin
		seed       = 32'h49e;
		RST_N      = 1'b0;
		CE         = 1'b0;
		op_valid   = 1'b0;
		op_code    = ADD;
		op_rn      = '0;
		op_rm      = '0;
		op_imm     = '0;
		model_t    = 1'b0;
		checks_on  = 1'b0;
		issued     = 0;
		pulses     = 0;
		data_errs  = 0;
		t_errs     = 0;
		hold_errs  = 0;
		other_errs = 0;
		test_name  = "reset";
		for (int i = 0; i < REG_COUNT; i++) begin
			model_regs[i] = '0;
		end
		repeat (2) @(posedge CLK);
		#1;
		RST_N     = 1'b1;
		CE        = 1'b1;
		checks_on = 1'b1;
		assert (wb_valid == 1'b0 && t_flag == 1'b0) else begin
			other_errs++;
			$display("[ERROR] %s: wb_valid/t_flag expected 0/0 actual %b/%b",
				test_name, wb_valid, t_flag);
		end
		for (int i = 0; i < REG_COUNT; i++) begin
			issue_op(MOV, 4'(i), 4'(i), 8'h00);
		end

		test_name = "forward_chain";
		for (int gap = 0; gap < 4; gap++) begin
			dependent_chain(gap);
		end

		test_name = "t_to_addc";
		t_into_addc(12);

		test_name = "random_mix";
		random_ops(300, 1'b0);

		test_name = "ce_stalls";
		random_ops(200, 1'b1);

		test_name = "drain";
		for (int cyc = 0; cyc < 20 && pulses < issued; cyc++) begin
			idle(1);
		end
		if (pulses < issued) begin
			$display("Timeout: %0d of %0d ops never reached write-back", issued - pulses, issued);
			finish_run(1'b1);
		end
		else begin
			idle(4);
			assert (pulses == issued && exp_rn_q.size() == 0) else begin
				other_errs++;
				$display("[ERROR] %s: write-back count expected %0d actual %0d",
					test_name, issued, pulses);
			end
			finish_run(1'b0);
		end
	end

endmodule

// ==== verilog/fwd_if.sv ====
`timescale 1ns/100ps

interface fwd_if;
	import sh_pkg::*;

	// Later stages with the nearest first
	reg_num_t ma_rn;
	logic     ma_wr;
	word_t    ma_res;
	reg_num_t wb_rn;
	logic     wb_wr;
	word_t    wb_res;
	reg_num_t wb2_rn;
	logic     wb2_wr;
	word_t    wb2_res;

	modport stages (
		output ma_rn, ma_wr, ma_res, wb_rn, wb_wr, wb_res, wb2_rn, wb2_wr, wb2_res
	);

	modport bypass (
		input ma_rn, ma_wr, ma_res, wb_rn, wb_wr, wb_res, wb2_rn, wb2_wr, wb2_res
	);

endinterface

// ==== verilog/sh_alu.sv ====
`timescale 1ns/100ps

module sh_alu (
	input  sh_pkg::alu_op_t op,
	input  sh_pkg::word_t   opa,
	input  sh_pkg::word_t   opb,
	input  logic            t_in,
	output sh_pkg::word_t   res,
	output logic            t_out,
	output logic            t_set
);

	import sh_pkg::*;

	word_t adder_res;
	logic  adder_c;
	logic  adder_eq;
	logic  adder_gt;
	word_t log_res;
	word_t shift_res;
	logic  shift_c;

	//******************************
	// Adder
	//******************************
	always_comb begin
		logic          sub;
		logic          cin;
		word_t         b_in;
		logic [WORD_W:0] sum;
		logic          ovf;

		sub  = op inside {SUB, CMP_EQ, CMP_HS, CMP_GT};
		b_in = sub ? ~opb : opb;
		cin  = sub | ((op == ADDC) & t_in);
		sum  = {1'b0, opa} + {1'b0, b_in} + {{WORD_W{1'b0}}, cin};
		// Overflow of a - b
		ovf  = (opa[WORD_W-1] ^ opb[WORD_W-1]) & (sum[WORD_W-1] ^ opa[WORD_W-1]);

		adder_res = sum[WORD_W-1:0];
		adder_c   = sum[WORD_W];
		adder_eq  = (sum[WORD_W-1:0] == '0);
		adder_gt  = ~(sum[WORD_W-1] ^ ovf) & ~adder_eq;
	end

	//******************************
	// Logic and shifter
	//******************************
	always_comb begin
		case (op)
			AND_:    log_res = opa & opb;
			OR_:     log_res = opa | opb;
			XOR_:    log_res = opa ^ opb;
			default: log_res = opb;
		endcase
	end

	always_comb begin
		if (op == SHLR) begin
			shift_res = {1'b0, opa[WORD_W-1:1]};
			shift_c   = opa[0];
		end
		else begin
			shift_res = {opa[WORD_W-2:0], 1'b0};
			shift_c   = opa[WORD_W-1];
		end
	end

	// Result and T select
	always_comb begin
		res   = adder_res;
		t_out = 1'b0;
		case (op)
			ADDC:                    t_out = adder_c;
			CMP_EQ:                  t_out = adder_eq;
			CMP_HS:                  t_out = adder_c;
			CMP_GT:                  t_out = adder_gt;
			AND_, OR_, XOR_, MOV, MOVI: res = log_res;
			SHLL, SHLR: begin
				res   = shift_res;
				t_out = shift_c;
			end
			default: ;
		endcase
	end

	assign t_set = op inside {ADDC, CMP_EQ, CMP_HS, CMP_GT, SHLL, SHLR};

endmodule

// ==== verilog/sh_bypass.sv ====
`timescale 1ns/100ps

module sh_bypass (
	input  sh_pkg::stage_t   ex,
	input  sh_pkg::reg_num_t ex_rm,
	input  sh_pkg::word_t    ex_a_raw,
	input  sh_pkg::word_t    ex_b_raw,
	input  sh_pkg::imm8_t    ex_imm,
	fwd_if.bypass            fwd,
	output sh_pkg::word_t    opa,
	output sh_pkg::word_t    opb
);

	import sh_pkg::*;

	word_t imm_ext;
	word_t rm_val;

	// Newest producer wins
	function automatic word_t fwd_pick(reg_num_t num, word_t raw);
		word_t val;
		if (fwd.ma_wr && fwd.ma_rn == num) begin
			val = fwd.ma_res;
		end
		else if (fwd.wb_wr && fwd.wb_rn == num) begin
			val = fwd.wb_res;
		end
		else if (fwd.wb2_wr && fwd.wb2_rn == num) begin
			val = fwd.wb2_res;
		end
		else begin
			val = raw;
		end
		return val;
	endfunction

	assign imm_ext = {{(WORD_W-IMM_W){ex_imm[IMM_W-1]}}, ex_imm};

	//******************************
	// Operand A is always Rn
	//******************************
	always_comb begin
		opa = fwd_pick(ex.rn, ex_a_raw);
	end

	//******************************
	// Operand B is Rm or imm8
	//******************************
	always_comb begin
		rm_val = fwd_pick(ex_rm, ex_b_raw);
	end

	always_comb begin
		if (op_uses_imm(ex.op)) begin
			opb = imm_ext;
		end
		else begin
			opb = rm_val;
		end
	end

endmodule

// ==== verilog/sh_core.sv ====
`timescale 1ns/100ps

module sh_core (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic             CE,
	input  logic             op_valid,
	input  sh_pkg::alu_op_t  op_code,
	input  sh_pkg::reg_num_t op_rn,
	input  sh_pkg::reg_num_t op_rm,
	input  sh_pkg::imm8_t    op_imm,
	output logic             wb_valid,
	output sh_pkg::reg_num_t wb_rn,
	output sh_pkg::word_t    wb_data,
	output logic             t_flag
);

	import sh_pkg::*;

	word_t    ra_data;
	word_t    rb_data;
	stage_t   ex;
	reg_num_t ex_rm;
	word_t    ex_a_raw;
	word_t    ex_b_raw;
	imm8_t    ex_imm;
	word_t    opa;
	word_t    opb;
	word_t    alu_res;
	logic     alu_t;
	logic     alu_t_set;
	reg_num_t wr_num;
	word_t    wr_data;
	logic     wr_en;

	fwd_if fwd ();

	sh_regfile i_sh_regfile (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.CE      (CE),
		.ra_num  (op_rn),
		.rb_num  (op_rm),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.wr_num  (wr_num),
		.wr_data (wr_data),
		.wr_en   (wr_en)
	);

	sh_bypass i_sh_bypass (
		.ex       (ex),
		.ex_rm    (ex_rm),
		.ex_a_raw (ex_a_raw),
		.ex_b_raw (ex_b_raw),
		.ex_imm   (ex_imm),
		.fwd      (fwd.bypass),
		.opa      (opa),
		.opb      (opb)
	);

	sh_alu i_sh_alu (
		.op    (ex.op),
		.opa   (opa),
		.opb   (opb),
		.t_in  (t_flag),
		.res   (alu_res),
		.t_out (alu_t),
		.t_set (alu_t_set)
	);

	sh_stages i_sh_stages (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.CE        (CE),
		.op_valid  (op_valid),
		.op_code   (op_code),
		.op_rn     (op_rn),
		.op_rm     (op_rm),
		.op_imm    (op_imm),
		.ra_data   (ra_data),
		.rb_data   (rb_data),
		.alu_res   (alu_res),
		.alu_t     (alu_t),
		.alu_t_set (alu_t_set),
		.ex        (ex),
		.ex_rm     (ex_rm),
		.ex_a_raw  (ex_a_raw),
		.ex_b_raw  (ex_b_raw),
		.ex_imm    (ex_imm),
		.t_flag    (t_flag),
		.fwd       (fwd.stages),
		.wr_num    (wr_num),
		.wr_data   (wr_data),
		.wr_en     (wr_en),
		.wb_valid  (wb_valid),
		.wb_rn     (wb_rn),
		.wb_data   (wb_data)
	);

endmodule

// ==== verilog/sh_pkg.sv ====
package sh_pkg;

	localparam int WORD_W    = 32;
	localparam int REG_NUM_W = 4;
	localparam int IMM_W     = 8;
	localparam int REG_COUNT = 16;

	typedef logic [REG_NUM_W-1:0] reg_num_t;
	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [IMM_W-1:0]     imm8_t;

	// Two-operand forms Rn = Rn op Rm or Rn = Rn op imm8
	typedef enum logic [3:0] {
		ADD,
		ADDC,
		SUB,
		AND_,
		OR_,
		XOR_,
		MOV,
		MOVI,
		ADDI,
		CMP_EQ,
		CMP_HS,
		CMP_GT,
		SHLL,
		SHLR
	} alu_op_t;

	typedef struct packed {
		logic     valid;
		alu_op_t  op;
		reg_num_t rn;
		logic     wr;
		word_t    res;
	} stage_t;

	localparam stage_t STAGE_EMPTY = '0;

	// Compares only touch T
	function automatic logic op_writes_reg(alu_op_t op);
		return !(op inside {CMP_EQ, CMP_HS, CMP_GT});
	endfunction

	function automatic logic op_uses_imm(alu_op_t op);
		return op inside {MOVI, ADDI};
	endfunction

endpackage

// ==== verilog/sh_regfile.sv ====
`timescale 1ns/100ps

module sh_regfile (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic             CE,
	input  sh_pkg::reg_num_t ra_num,
	input  sh_pkg::reg_num_t rb_num,
	output sh_pkg::word_t    ra_data,
	output sh_pkg::word_t    rb_data,
	input  sh_pkg::reg_num_t wr_num,
	input  sh_pkg::word_t    wr_data,
	input  logic             wr_en
);

	import sh_pkg::*;

	word_t regs [REG_COUNT];

	// Single write port fed from WB
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end
		else if (CE && wr_en) begin
			regs[wr_num] <= wr_data;
		end
	end

	// Old value on a same-cycle write is covered by WB2 forwarding
	assign ra_data = regs[ra_num];
	assign rb_data = regs[rb_num];

endmodule

// ==== verilog/sh_stages.sv ====
`timescale 1ns/100ps

module sh_stages (
	input  logic             CLK,
	input  logic             RST_N,
	input  logic             CE,
	input  logic             op_valid,
	input  sh_pkg::alu_op_t  op_code,
	input  sh_pkg::reg_num_t op_rn,
	input  sh_pkg::reg_num_t op_rm,
	input  sh_pkg::imm8_t    op_imm,
	input  sh_pkg::word_t    ra_data,
	input  sh_pkg::word_t    rb_data,
	input  sh_pkg::word_t    alu_res,
	input  logic             alu_t,
	input  logic             alu_t_set,
	output sh_pkg::stage_t   ex,
	output sh_pkg::reg_num_t ex_rm,
	output sh_pkg::word_t    ex_a_raw,
	output sh_pkg::word_t    ex_b_raw,
	output sh_pkg::imm8_t    ex_imm,
	output logic             t_flag,
	fwd_if.stages            fwd,
	output sh_pkg::reg_num_t wr_num,
	output sh_pkg::word_t    wr_data,
	output logic             wr_en,
	output logic             wb_valid,
	output sh_pkg::reg_num_t wb_rn,
	output sh_pkg::word_t    wb_data
);

	import sh_pkg::*;

	stage_t   ex_q;
	stage_t   ma_q;
	stage_t   wb_q;
	stage_t   wb2_q;
	reg_num_t ex_rm_q;
	imm8_t    ex_imm_q;
	word_t    ex_b_q;
	logic     t_q;

	//******************************
	// Pipeline advance on CE edges
	//******************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			ex_q     <= STAGE_EMPTY;
			ma_q     <= STAGE_EMPTY;
			wb_q     <= STAGE_EMPTY;
			wb2_q    <= STAGE_EMPTY;
			ex_rm_q  <= '0;
			ex_imm_q <= '0;
			ex_b_q   <= '0;
			t_q      <= 1'b0;
		end
		else if (CE) begin
			// EX res slot holds the raw Rn read until the ALU runs
			ex_q.valid <= op_valid;
			ex_q.op    <= op_code;
			ex_q.rn    <= op_rn;
			ex_q.wr    <= op_valid && op_writes_reg(op_code);
			ex_q.res   <= ra_data;
			ex_rm_q    <= op_rm;
			ex_imm_q   <= op_imm;
			ex_b_q     <= rb_data;

			ma_q     <= ex_q;
			ma_q.res <= alu_res;
			wb_q     <= ma_q;
			wb2_q    <= wb_q;

			if (ex_q.valid && alu_t_set) begin
				t_q <= alu_t;
			end
		end
	end

	assign ex       = ex_q;
	assign ex_rm    = ex_rm_q;
	assign ex_a_raw = ex_q.res;
	assign ex_b_raw = ex_b_q;
	assign ex_imm   = ex_imm_q;
	assign t_flag   = t_q;

	// Forwarding taps
	assign fwd.ma_rn   = ma_q.rn;
	assign fwd.ma_wr   = ma_q.wr;
	assign fwd.ma_res  = ma_q.res;
	assign fwd.wb_rn   = wb_q.rn;
	assign fwd.wb_wr   = wb_q.wr;
	assign fwd.wb_res  = wb_q.res;
	assign fwd.wb2_rn  = wb2_q.rn;
	assign fwd.wb2_wr  = wb2_q.wr;
	assign fwd.wb2_res = wb2_q.res;

	assign wr_num   = wb_q.rn;
	assign wr_data  = wb_q.res;
	assign wr_en    = wb_q.wr;
	assign wb_valid = wb_q.valid;
	assign wb_rn    = wb_q.rn;
	assign wb_data  = wb_q.res;

endmodule
